// File: logic/axi_lite_pkg.sv
// AXI bus widths, response codes and bus vector types
`default_nettype none

package axi_lite_pkg;

  localparam int AXI_ADDR_W = 64;
  localparam int AXI_DATA_W = 64;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;
  localparam int AXI_ID_W   = 4;
  localparam int AXI_RESP_W = 2;

  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [AXI_STRB_W-1:0] axi_strb_t;
  typedef logic [AXI_ID_W-1:0]   axi_id_t;
  typedef logic [AXI_RESP_W-1:0] axi_resp_t;

  // response codes
  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_EXOKAY = 2'b01;
  localparam axi_resp_t RESP_SLVERR = 2'b10;
  localparam axi_resp_t RESP_DECERR = 2'b11;

endpackage

`default_nettype wire

// File: logic/clint_pkg.sv
// CLINT register addresses, reset values and register types
`default_nettype none

package clint_pkg;

  localparam int MSIP_W  = 32;
  localparam int MTIME_W = 64;

  // msip is 32 bits, timer and compare are 64
  typedef logic [MSIP_W-1:0]  msip_t;
  typedef logic [MTIME_W-1:0] mtime_t;

  // machine-mode register map
  localparam logic [63:0] MSIP_ADDR     = 64'h0000_0000_0200_0000;
  localparam logic [63:0] MTIMECMP_ADDR = 64'h0000_0000_0200_4000;
  localparam logic [63:0] MTIME_ADDR    = 64'h0000_0000_0200_BFF8;

  // reset values
  localparam msip_t  MSIP_RST     = '0;
  localparam mtime_t MTIME_RST    = '0;
  localparam mtime_t MTIMECMP_RST = 64'h0000_0000_0008_0000;

endpackage

`default_nettype wire

// File: logic/clint_rd_port.sv
// read-channel FSM that captures AR and returns a single R beat
`default_nettype none

module clint_rd_port
  import axi_lite_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  logic      ar_valid_i,
  input  axi_addr_t ar_addr_i,
  input  axi_id_t   ar_id_i,
  output logic      ar_ready_o,

  input  logic      r_ready_i,
  output logic      r_valid_o,
  output axi_data_t r_data_o,
  output axi_resp_t r_resp_o,
  output logic      r_last_o,
  output axi_id_t   r_id_o,

  output axi_addr_t rd_addr_o,
  input  axi_data_t rd_data_i
);

  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

  rd_state_e state_q;
  axi_addr_t addr_q;
  axi_id_t   id_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= RD_IDLE;
    end else begin
      case (state_q)
        RD_IDLE: if (ar_valid_i) state_q <= RD_RESP;
        RD_RESP: if (r_ready_i) state_q <= RD_IDLE;
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  // payload latched on the AR handshake
  always_ff @(posedge clk) begin
    if (ar_valid_i && ar_ready_o) begin
      addr_q <= ar_addr_i;
      id_q   <= ar_id_i;
    end
  end

  assign ar_ready_o = (state_q == RD_IDLE);
  assign r_valid_o  = (state_q == RD_RESP);
  assign r_last_o   = r_valid_o;
  assign r_id_o     = id_q;
  assign r_resp_o   = RESP_OKAY;
  // data follows the registers until the beat is taken
  assign r_data_o   = rd_data_i;
  assign rd_addr_o  = addr_q;

  a_r_hold: assert property (@(posedge clk) disable iff (rst)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_id_o));

  a_ar_capture: assert property (@(posedge clk) disable iff (rst)
    ar_valid_i && ar_ready_o |=>
      r_valid_o && rd_addr_o == $past(ar_addr_i) && r_id_o == $past(ar_id_i));

endmodule

`default_nettype wire

// File: logic/clint_wr_port.sv
// write-channel FSM for AW, W and B that issues register write strobes
`default_nettype none

module clint_wr_port
  import axi_lite_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  logic      aw_valid_i,
  input  axi_addr_t aw_addr_i,
  input  axi_id_t   aw_id_i,
  output logic      aw_ready_o,

  input  logic      w_valid_i,
  input  axi_data_t w_data_i,
  input  axi_strb_t w_strb_i,
  input  logic      w_last_i,
  output logic      w_ready_o,

  input  logic      b_ready_i,
  output logic      b_valid_o,
  output axi_resp_t b_resp_o,
  output axi_id_t   b_id_o,

  output logic      wr_en_o,
  output axi_addr_t wr_addr_o,
  output axi_data_t wr_data_o,
  output axi_strb_t wr_strb_o
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  wr_state_e state_q;
  axi_addr_t addr_q;
  axi_id_t   id_q;
  logic      w_hs;

  assign w_hs = w_valid_i && w_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= WR_IDLE;
    end else begin
      case (state_q)
        WR_IDLE: if (aw_valid_i) state_q <= WR_DATA;
        // burst ends on the last beat, not on a beat count
        WR_DATA: if (w_hs && w_last_i) state_q <= WR_RESP;
        WR_RESP: if (b_ready_i) state_q <= WR_IDLE;
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_valid_i && aw_ready_o) begin
      addr_q <= aw_addr_i;
      id_q   <= aw_id_i;
    end
  end

  assign aw_ready_o = (state_q == WR_IDLE);
  assign w_ready_o  = (state_q == WR_DATA);
  assign b_valid_o  = (state_q == WR_RESP);
  assign b_resp_o   = RESP_OKAY;
  assign b_id_o     = id_q;

  // every beat lands on the captured address
  assign wr_en_o    = w_hs;
  assign wr_addr_o  = addr_q;
  assign wr_data_o  = w_data_i;
  assign wr_strb_o  = w_strb_i;

  a_last_to_b: assert property (@(posedge clk) disable iff (rst)
    w_hs && w_last_i |=> b_valid_o && !w_ready_o);

  a_b_hold: assert property (@(posedge clk) disable iff (rst)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_id_o));

endmodule

`default_nettype wire

// File: logic/clint_regs.sv
// msip, mtimecmp and mtime registers with decode, strobe merge and interrupts
`default_nettype none

module clint_regs
  import axi_lite_pkg::*;
  import clint_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  logic      wr_en_i,
  input  axi_addr_t wr_addr_i,
  input  axi_data_t wr_data_i,
  input  axi_strb_t wr_strb_i,

  input  axi_addr_t rd_addr_i,
  output axi_data_t rd_data_o,

  output logic      soft_irq_o,
  output logic      timer_irq_o
);

  msip_t     msip_q;
  mtime_t    mtimecmp_q;
  mtime_t    mtime_q;
  axi_data_t wr_mask;
  logic      wr_msip;
  logic      wr_mtimecmp;
  logic      wr_mtime;

  // one strobe bit covers one byte lane
  always_comb begin
    for (int i = 0; i < AXI_STRB_W; i++) begin
      wr_mask[i*8 +: 8] = {8{wr_strb_i[i]}};
    end
  end

  assign wr_msip     = wr_en_i && (wr_addr_i == MSIP_ADDR);
  assign wr_mtimecmp = wr_en_i && (wr_addr_i == MTIMECMP_ADDR);
  assign wr_mtime    = wr_en_i && (wr_addr_i == MTIME_ADDR);

  always_ff @(posedge clk) begin
    if (rst) begin
      msip_q     <= MSIP_RST;
      mtimecmp_q <= MTIMECMP_RST;
      mtime_q    <= MTIME_RST;
    end else begin
      if (wr_msip) begin
        msip_q <= (msip_q & ~wr_mask[MSIP_W-1:0]) | (wr_data_i[MSIP_W-1:0] & wr_mask[MSIP_W-1:0]);
      end
      if (wr_mtimecmp) begin
        mtimecmp_q <= (mtimecmp_q & ~wr_mask) | (wr_data_i & wr_mask);
      end
      // a write takes the place of this cycle's tick
      if (wr_mtime) begin
        mtime_q <= (mtime_q & ~wr_mask) | (wr_data_i & wr_mask);
      end else begin
        mtime_q <= mtime_q + 64'd1;
      end
    end
  end

  always_comb begin
    case (rd_addr_i)
      MSIP_ADDR:     rd_data_o = {{(AXI_DATA_W - MSIP_W){msip_q[MSIP_W-1]}}, msip_q};
      MTIMECMP_ADDR: rd_data_o = mtimecmp_q;
      MTIME_ADDR:    rd_data_o = mtime_q;
      default:       rd_data_o = '0;
    endcase
  end

  assign soft_irq_o  = msip_q[0];
  assign timer_irq_o = (mtime_q >= mtimecmp_q);

  // unmapped writes are dropped, the timer still ticks
  a_unmapped_wr: assert property (@(posedge clk) disable iff (rst)
    wr_en_i && !(wr_msip || wr_mtimecmp || wr_mtime) |=>
      $stable(msip_q) && $stable(mtimecmp_q) && (mtime_q == $past(mtime_q) + 64'd1));

endmodule

`default_nettype wire

// File: logic/clint.sv
// CLINT top level joining the read port, the write port and the register block
`default_nettype none

module clint
  import axi_lite_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  logic      aw_valid_i,
  input  axi_addr_t aw_addr_i,
  input  axi_id_t   aw_id_i,
  output logic      aw_ready_o,

  input  logic      w_valid_i,
  input  axi_data_t w_data_i,
  input  axi_strb_t w_strb_i,
  input  logic      w_last_i,
  output logic      w_ready_o,

  input  logic      b_ready_i,
  output logic      b_valid_o,
  output axi_resp_t b_resp_o,
  output axi_id_t   b_id_o,

  input  logic      ar_valid_i,
  input  axi_addr_t ar_addr_i,
  input  axi_id_t   ar_id_i,
  output logic      ar_ready_o,

  input  logic      r_ready_i,
  output logic      r_valid_o,
  output axi_data_t r_data_o,
  output axi_resp_t r_resp_o,
  output logic      r_last_o,
  output axi_id_t   r_id_o,

  output logic      soft_irq_o,
  output logic      timer_irq_o
);

  axi_addr_t rd_addr;
  axi_data_t rd_data;
  logic      wr_en;
  axi_addr_t wr_addr;
  axi_data_t wr_data;
  axi_strb_t wr_strb;

  clint_rd_port u_rd_port (
    .clk        (clk),
    .rst        (rst),
    .ar_valid_i (ar_valid_i),
    .ar_addr_i  (ar_addr_i),
    .ar_id_i    (ar_id_i),
    .ar_ready_o (ar_ready_o),
    .r_ready_i  (r_ready_i),
    .r_valid_o  (r_valid_o),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o),
    .r_last_o   (r_last_o),
    .r_id_o     (r_id_o),
    .rd_addr_o  (rd_addr),
    .rd_data_i  (rd_data)
  );

  clint_wr_port u_wr_port (
    .clk        (clk),
    .rst        (rst),
    .aw_valid_i (aw_valid_i),
    .aw_addr_i  (aw_addr_i),
    .aw_id_i    (aw_id_i),
    .aw_ready_o (aw_ready_o),
    .w_valid_i  (w_valid_i),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .w_last_i   (w_last_i),
    .w_ready_o  (w_ready_o),
    .b_ready_i  (b_ready_i),
    .b_valid_o  (b_valid_o),
    .b_resp_o   (b_resp_o),
    .b_id_o     (b_id_o),
    .wr_en_o    (wr_en),
    .wr_addr_o  (wr_addr),
    .wr_data_o  (wr_data),
    .wr_strb_o  (wr_strb)
  );

  clint_regs u_regs (
    .clk         (clk),
    .rst         (rst),
    .wr_en_i     (wr_en),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .wr_strb_i   (wr_strb),
    .rd_addr_i   (rd_addr),
    .rd_data_o   (rd_data),
    .soft_irq_o  (soft_irq_o),
    .timer_irq_o (timer_irq_o)
  );

endmodule

`default_nettype wire

// File: tb/clint_tb.sv
// testbench for the CLINT: clock, reset, random AXI master, register model and checks
`default_nettype none

module clint_tb
  import axi_lite_pkg::*;
  import clint_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 64;
  localparam logic [63:0] UNMAPPED_ADDR = 64'h0000_0000_0200_1000;

  logic clk, rst;
  logic aw_valid, aw_ready, w_valid, w_last, w_ready, b_ready, b_valid;
  logic ar_valid, ar_ready, r_ready, r_valid, r_last, soft_irq, timer_irq;
  axi_addr_t aw_addr, ar_addr, aw_addr_c, ar_addr_c, wr_pick, rd_pick;
  axi_id_t aw_id, b_id, ar_id, r_id, aw_id_c, ar_id_c;
  axi_data_t w_data, r_data, rd_val;
  axi_strb_t w_strb;
  axi_resp_t b_resp, r_resp;
  msip_t m_msip;
  mtime_t m_mtimecmp, m_mtime;
  logic rd_open, wr_open;
  int errors = 0, tests_failed = 0, test_start_errors = 0;
  int n_r = 0, n_b = 0, n_rd_req = 0, n_wr_req = 0;

  clint u_dut (
    .clk(clk), .rst(rst),
    .aw_valid_i(aw_valid), .aw_addr_i(aw_addr), .aw_id_i(aw_id), .aw_ready_o(aw_ready),
    .w_valid_i(w_valid), .w_data_i(w_data), .w_strb_i(w_strb), .w_last_i(w_last),
    .w_ready_o(w_ready),
    .b_ready_i(b_ready), .b_valid_o(b_valid), .b_resp_o(b_resp), .b_id_o(b_id),
    .ar_valid_i(ar_valid), .ar_addr_i(ar_addr), .ar_id_i(ar_id), .ar_ready_o(ar_ready),
    .r_ready_i(r_ready), .r_valid_o(r_valid), .r_data_o(r_data), .r_resp_o(r_resp),
    .r_last_o(r_last), .r_id_o(r_id),
    .soft_irq_o(soft_irq), .timer_irq_o(timer_irq)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [63:0] merge_bytes(logic [63:0] old, logic [63:0] data,
                                              axi_strb_t strb);
    logic [63:0] res;
    res = old;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) res[i*8 +: 8] = data[i*8 +: 8];
    end
    return res;
  endfunction

  // msip reads back sign-extended, holes read as zero
  function automatic axi_data_t expected_read(axi_addr_t addr);
    if (addr == MSIP_ADDR) return {{32{m_msip[31]}}, m_msip};
    if (addr == MTIMECMP_ADDR) return m_mtimecmp;
    if (addr == MTIME_ADDR) return m_mtime;
    return '0;
  endfunction

  task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
    $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    errors++;
  endtask

  task automatic report_error(string what);
    $display("error at %0t: %s", $time, what);
    errors++;
  endtask

  // model steps at every rising edge, checks use the values before the edge
  always @(posedge clk) begin : monitor
    logic [63:0] merged;
    if (rst) begin
      m_msip = '0;
      m_mtimecmp = MTIMECMP_RST;
      m_mtime = '0;
      rd_open = 1'b0;
      wr_open = 1'b0;
    end else begin
      if (timer_irq !== (m_mtime >= m_mtimecmp))
        report_mismatch("timer_irq_o", 64'(m_mtime >= m_mtimecmp), 64'(timer_irq));
      if (soft_irq !== m_msip[0])
        report_mismatch("soft_irq_o", 64'(m_msip[0]), 64'(soft_irq));
      if (r_valid && !rd_open) report_error("r_valid_o high without an open read");
      if (ar_valid && ar_ready) begin
        ar_addr_c = ar_addr;
        ar_id_c = ar_id;
        rd_open = 1'b1;
      end
      if (r_valid && r_ready) begin
        if (r_data !== expected_read(ar_addr_c))
          report_mismatch("r_data_o", expected_read(ar_addr_c), r_data);
        if (r_id !== ar_id_c) report_mismatch("r_id_o", 64'(ar_id_c), 64'(r_id));
        if (r_resp !== RESP_OKAY || r_last !== 1'b1) report_error("R beat not OKAY or not last");
        rd_open = 1'b0;
        n_r++;
      end
      if (b_valid && !wr_open) report_error("b_valid_o high without an open write");
      if (aw_valid && aw_ready) begin
        aw_addr_c = aw_addr;
        aw_id_c = aw_id;
        wr_open = 1'b1;
      end
      if (b_valid && b_ready) begin
        if (b_id !== aw_id_c) report_mismatch("b_id_o", 64'(aw_id_c), 64'(b_id));
        if (b_resp !== RESP_OKAY) report_mismatch("b_resp_o", 64'(RESP_OKAY), 64'(b_resp));
        wr_open = 1'b0;
        n_b++;
      end
      if (w_valid && w_ready && aw_addr_c == MSIP_ADDR) begin
        merged = merge_bytes({32'd0, m_msip}, w_data, w_strb);
        m_msip = merged[31:0];
      end
      if (w_valid && w_ready && aw_addr_c == MTIMECMP_ADDR)
        m_mtimecmp = merge_bytes(m_mtimecmp, w_data, w_strb);
      if (w_valid && w_ready && aw_addr_c == MTIME_ADDR)
        m_mtime = merge_bytes(m_mtime, w_data, w_strb);
      else
        m_mtime = m_mtime + 64'd1;
    end
  end

  function automatic logic channel_ready(int ch);
    case (ch)
      0: return ar_ready;
      1: return r_valid;
      2: return aw_ready;
      3: return w_ready;
      default: return b_valid;
    endcase
  endfunction

  task automatic wait_handshake(int ch, string what);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!channel_ready(ch) && n < WAIT_LIMIT);
    if (!channel_ready(ch)) report_error({"timeout waiting for ", what});
  endtask

  task automatic read_reg(input axi_addr_t addr, output axi_data_t data);
    n_rd_req++;
    repeat ($urandom_range(0, 2)) @(negedge clk);
    ar_valid = 1'b1;
    ar_addr = addr;
    ar_id = axi_id_t'($urandom);
    wait_handshake(0, "ar_ready_o");
    @(negedge clk);
    ar_valid = 1'b0;
    repeat ($urandom_range(0, 3)) @(negedge clk);
    r_ready = 1'b1;
    wait_handshake(1, "r_valid_o");
    data = r_data;
    @(negedge clk);
    r_ready = 1'b0;
  endtask

  // earlier beats carry random data, the last beat the given one
  task automatic write_burst(axi_addr_t addr, int beats, axi_data_t data, axi_strb_t strb);
    n_wr_req++;
    repeat ($urandom_range(0, 2)) @(negedge clk);
    aw_valid = 1'b1;
    aw_addr = addr;
    aw_id = axi_id_t'($urandom);
    wait_handshake(2, "aw_ready_o");
    @(negedge clk);
    aw_valid = 1'b0;
    for (int k = 1; k <= beats; k++) begin
      w_valid = 1'b1;
      w_last = (k == beats);
      w_data = (k == beats) ? data : {$urandom, $urandom};
      w_strb = (k == beats) ? strb : axi_strb_t'($urandom);
      wait_handshake(3, "w_ready_o");
      @(negedge clk);
      w_valid = 1'b0;
      w_last = 1'b0;
      repeat ($urandom_range(0, 1)) @(negedge clk);
    end
    repeat ($urandom_range(0, 3)) @(negedge clk);
    b_ready = 1'b1;
    wait_handshake(4, "b_valid_o");
    @(negedge clk);
    b_ready = 1'b0;
  endtask

  function automatic axi_addr_t pick_addr();
    case ($urandom_range(0, 4))
      0: return MSIP_ADDR;
      1: return MTIMECMP_ADDR;
      2: return MTIME_ADDR;
      3: return UNMAPPED_ADDR;
      default: return MSIP_ADDR + 64'h8;
    endcase
  endfunction

  task automatic finish_test(int num, string name);
    if (errors == test_start_errors) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - test_start_errors);
      tests_failed++;
    end
    test_start_errors = errors;
  endtask

  initial begin
    void'($urandom(32'h4566));
    rst = 1'b1;
    {aw_valid, w_valid, w_last, b_ready, ar_valid, r_ready} = '0;
    {aw_addr, ar_addr, w_data} = '0;
    {aw_id, ar_id, w_strb} = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    if (ar_ready !== 1'b1 || aw_ready !== 1'b1) report_error("ready outputs low after reset");
    if (w_ready !== 1'b0 || r_valid !== 1'b0 || b_valid !== 1'b0)
      report_error("w_ready_o or a valid output high after reset");
    if (soft_irq !== 1'b0 || timer_irq !== 1'b0) report_error("interrupt high after reset");
    read_reg(MSIP_ADDR, rd_val);
    if (rd_val !== 64'd0) report_mismatch("r_data_o", 64'd0, rd_val);
    read_reg(MTIMECMP_ADDR, rd_val);
    if (rd_val !== MTIMECMP_RST) report_mismatch("r_data_o", MTIMECMP_RST, rd_val);
    finish_test(1, "reset values");

    repeat (24) begin
      wr_pick = $urandom_range(0, 1) ? MSIP_ADDR : MTIMECMP_ADDR;
      write_burst(wr_pick, $urandom_range(1, 4), {$urandom, $urandom}, axi_strb_t'($urandom));
      read_reg(wr_pick, rd_val);
    end
    finish_test(2, "msip and mtimecmp writes");

    repeat (12) begin
      write_burst(MTIME_ADDR, $urandom_range(1, 2), {$urandom, $urandom}, axi_strb_t'($urandom));
      read_reg(MTIME_ADDR, rd_val);
      repeat ($urandom_range(0, 5)) @(negedge clk);
      read_reg(MTIME_ADDR, rd_val);
    end
    finish_test(3, "mtime reads");

    // move the compare point close to the count, or far away
    repeat (18) begin
      case ($urandom_range(0, 2))
        0: write_burst(MTIMECMP_ADDR, 1, m_mtime + 64'($urandom_range(0, 24)), 8'hff);
        1: write_burst(MTIME_ADDR, 1, m_mtimecmp - 64'($urandom_range(0, 24)), 8'hff);
        default: write_burst(MTIMECMP_ADDR, 1, {$urandom, $urandom}, axi_strb_t'($urandom));
      endcase
      repeat (30) @(negedge clk);
    end
    finish_test(4, "timer interrupt");

    repeat (16) begin
      write_burst(MSIP_ADDR, 1, {$urandom, $urandom}, axi_strb_t'($urandom));
      repeat ($urandom_range(0, 4)) @(negedge clk);
    end
    finish_test(5, "software interrupt");

    fork
      repeat (20) begin
        wr_pick = pick_addr();
        write_burst(wr_pick, $urandom_range(1, 4), {$urandom, $urandom}, axi_strb_t'($urandom));
      end
      repeat (20) begin
        rd_pick = pick_addr();
        read_reg(rd_pick, rd_val);
      end
    join
    repeat (4) @(negedge clk);
    if (n_r != n_rd_req) report_error("number of R beats differs from reads issued");
    if (n_b != n_wr_req) report_error("number of B responses differs from writes issued");
    finish_test(6, "overlapped traffic with stalls");

    $display("tests run 6, tests failed %0d, errors %0d", tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
logic/axi_lite_pkg.sv
logic/clint_pkg.sv
logic/clint_rd_port.sv
logic/clint_wr_port.sv
logic/clint_regs.sv
logic/clint.sv
tb/clint_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the CLINT testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module clint_tb \
  -Mdir obj_dir -o clint_sim

./obj_dir/clint_sim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "run failed"
  exit 1
fi
echo "run passed"
